// File: hdl/bar_regfile.sv
// BAR0 register bank that executes parsed requests and issues completion records for reads.
`timescale 1ns/10ps

module bar_regfile (
    input  logic                     clk,
    input  logic                     rst,

    input  pcie_core_pkg::req_rec_t  req,
    input  logic                     req_valid,
    output logic                     req_ready,

    output pcie_core_pkg::cpl_rec_t  cpl,
    output logic                     cpl_valid,
    input  logic                     cpl_ready,

    input  logic [3:0]               sw,
    input  logic                     btnu,
    input  logic                     btnl,
    input  logic                     btnd,
    input  logic                     btnr,
    input  logic                     btnc,
    output pcie_core_pkg::led_t      led,
    output logic                     status_error_uncor
);

    import pcie_core_pkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_WIDTH;

    data_word_t regs [NUM_REGS];
    data_word_t status_word;
    data_word_t rd_data;
    logic       take;
    logic       is_read_kind;
    logic       is_bad_kind;

    // switches in 3:0, buttons u l d r c in 8:4.
    assign status_word = {23'd0, btnu, btnl, btnd, btnr, btnc, sw};

    assign rd_data = (req.addr == REG_STATUS) ? status_word : regs[req.addr];

    assign is_read_kind = (req.kind == KIND_READ) || (req.kind == KIND_BAD_READ);
    assign is_bad_kind  = (req.kind == KIND_BAD_READ) || (req.kind == KIND_BAD_WRITE);

    // writes stall too, so requests leave this stage strictly in order.
    assign req_ready = !cpl_valid || cpl_ready;
    assign take      = req_valid && req_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register bank
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (take && (req.kind == KIND_WRITE) && (req.addr != REG_STATUS)) begin
            for (int b = 0; b < 4; b++) begin
                if (req.be[b]) begin
                    regs[req.addr][8*b +: 8] <= req.data[8*b +: 8];
                end
            end
        end
    end

    assign led = regs[REG_LED][7:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // completion record and error pulse
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            cpl_valid          <= 1'b0;
            status_error_uncor <= 1'b0;
        end else begin
            if (take && is_read_kind) begin
                cpl_valid <= 1'b1;
            end else if (cpl_ready) begin
                cpl_valid <= 1'b0;
            end
            status_error_uncor <= take && is_bad_kind; // one cycle per bad request.
        end
    end

    always_ff @(posedge clk) begin
        if (take && is_read_kind) begin
            if (req.kind == KIND_READ) begin
                cpl.status <= CPL_SC;
                cpl.data   <= rd_data;
            end else begin
                cpl.status <= CPL_UR;
                cpl.data   <= '0; // an unsupported request carries no data.
            end
            cpl.requester_id <= req.requester_id;
            cpl.tag          <= req.tag;
            cpl.lower_addr   <= req.lower_addr;
        end
    end

    // a write passing through may only hold or drain the record, never load one.
    a_no_cpl_from_write: assert property (
        @(posedge clk) disable iff (rst)
        take && ((req.kind == KIND_WRITE) || (req.kind == KIND_BAD_WRITE)) |=> !$rose(cpl_valid)
    );

endmodule

// File: hdl/cc_completion_gen.sv
// CC output stage that packs completion records into single-beat descriptors with back-pressure.
`timescale 1ns/10ps

module cc_completion_gen (
    input  logic                    clk,
    input  logic                    rst,

    input  pcie_core_pkg::cpl_rec_t cpl,
    input  logic                    cpl_valid,
    output logic                    cpl_ready,

    output pcie_core_pkg::cc_beat_t cc,
    output logic                    cc_valid,
    input  logic                    cc_ready
);

    import pcie_core_pkg::*;

    cc_beat_t next_beat;
    logic     is_sc;
    logic     take;

    assign is_sc = (cpl.status == CPL_SC);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // descriptor build
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        next_beat = '0;
        next_beat.data[CC_LOWER_ADDR_LSB +: LOWER_ADDR_WIDTH] = cpl.lower_addr;
        next_beat.data[CC_BYTE_COUNT_LSB +: BYTE_COUNT_WIDTH] = BYTE_COUNT_WIDTH'(4);
        next_beat.data[CC_STATUS_LSB +: 3]                    = cpl.status;
        next_beat.data[CC_REQ_ID_LSB +: 16]                   = cpl.requester_id;
        next_beat.data[CC_TAG_LSB +: 8]                       = cpl.tag;
        next_beat.last = 1'b1; // every completion fits in one beat.

        if (is_sc) begin
            next_beat.data[CC_DW_COUNT_LSB +: DW_COUNT_WIDTH] = DW_COUNT_WIDTH'(1);
            next_beat.data[CC_RD_DATA_LSB +: 32]              = cpl.data;
            next_beat.keep                                    = AXIS_KEEP_WIDTH'(8'h0f);
        end else begin
            // three descriptor dwords and no payload.
            next_beat.keep = AXIS_KEEP_WIDTH'(8'h07);
        end
    end

    assign cpl_ready = !cc_valid || cc_ready;
    assign take      = cpl_valid && cpl_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            cc_valid <= 1'b0;
        end else if (take) begin
            cc_valid <= 1'b1;
        end else if (cc_ready) begin
            cc_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            cc <= next_beat;
        end
    end

    // the link side sees a frozen beat until it accepts it.
    a_cc_hold: assert property (
        @(posedge clk) disable iff (rst)
        cc_valid && !cc_ready |=> cc_valid && $stable(cc)
    );

endmodule

// File: hdl/cq_request_parser.sv
// CQ input stage that accepts single-beat requests, extracts descriptor fields and classifies them.
`timescale 1ns/10ps

module cq_request_parser (
    input  logic                    clk,
    input  logic                    rst,

    input  pcie_core_pkg::cq_beat_t cq,
    input  logic                    cq_valid,
    output logic                    cq_ready,

    output pcie_core_pkg::req_rec_t req,
    output logic                    req_valid,
    input  logic                    req_ready
);

    import pcie_core_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // descriptor decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    req_type_t                 req_type;
    logic [BAR_ID_WIDTH-1:0]   bar_id;
    logic [DW_COUNT_WIDTH-1:0] dw_count;
    logic                      is_write;
    logic                      is_good;
    req_kind_t                 kind;
    logic                      take;

    assign req_type = cq.data[CQ_REQ_TYPE_LSB +: 4];
    assign bar_id   = cq.data[CQ_BAR_ID_LSB +: BAR_ID_WIDTH];
    assign dw_count = cq.data[CQ_DW_COUNT_LSB +: DW_COUNT_WIDTH];

    // anything that is not a memory write is answered like a read.
    assign is_write = (req_type == REQ_MEM_WRITE);

    assign is_good = ((req_type == REQ_MEM_READ) || (req_type == REQ_MEM_WRITE)) &&
                     (bar_id == '0) &&
                     (dw_count == DW_COUNT_WIDTH'(1));

    always_comb begin
        if (is_good) begin
            kind = is_write ? KIND_WRITE : KIND_READ;
        end else begin
            kind = is_write ? KIND_BAD_WRITE : KIND_BAD_READ;
        end
    end

    // the output register is free when empty or drained this cycle.
    assign cq_ready = !req_valid || req_ready;
    assign take     = cq_valid && cq_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
        end else if (take) begin
            req_valid <= 1'b1;
        end else if (req_ready) begin
            req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req.kind         <= kind;
            req.addr         <= cq.data[CQ_ADDR_LSB +: REG_ADDR_WIDTH]; // dword index in BAR0.
            req.be           <= cq.user[3:0];
            req.data         <= cq.data[CQ_WR_DATA_LSB +: 32];
            req.requester_id <= cq.data[CQ_REQ_ID_LSB +: 16];
            req.tag          <= cq.data[CQ_TAG_LSB +: 8];
            req.lower_addr   <= {cq.data[LOWER_ADDR_WIDTH-1:CQ_ADDR_LSB], 2'b00}; // byte address bits 6:0.
        end
    end

    // a stalled request must not change under the register file.
    a_req_hold: assert property (
        @(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req)
    );

endmodule

// File: hdl/fpga_core.sv
// Top level of the PCIe endpoint core that joins the CQ parser, BAR0 registers and CC generator.
`timescale 1ns/10ps

module fpga_core (
    // 250 MHz clock with synchronous reset.
    input  logic                    clk,
    input  logic                    rst,

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // GPIO
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    input  logic                    btnu,
    input  logic                    btnl,
    input  logic                    btnd,
    input  logic                    btnr,
    input  logic                    btnc,
    input  logic [3:0]              sw,
    output pcie_core_pkg::led_t     led,

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // PCIe completer streams
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    input  pcie_core_pkg::cq_beat_t cq,
    input  logic                    cq_valid,
    output logic                    cq_ready,

    output pcie_core_pkg::cc_beat_t cc,
    output logic                    cc_valid,
    input  logic                    cc_ready,

    output logic                    status_error_uncor
);

    import pcie_core_pkg::*;

    req_rec_t req;        // parsed request into the register file.
    logic     req_valid;
    logic     req_ready;
    cpl_rec_t cpl;        // completion record into the CC stage.
    logic     cpl_valid;
    logic     cpl_ready;

    cq_request_parser i_parser (
        .clk       (clk),
        .rst       (rst),
        .cq        (cq),
        .cq_valid  (cq_valid),
        .cq_ready  (cq_ready),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready)
    );

    bar_regfile i_regfile (
        .clk                (clk),
        .rst                (rst),
        .req                (req),
        .req_valid          (req_valid),
        .req_ready          (req_ready),
        .cpl                (cpl),
        .cpl_valid          (cpl_valid),
        .cpl_ready          (cpl_ready),
        .sw                 (sw),
        .btnu               (btnu),
        .btnl               (btnl),
        .btnd               (btnd),
        .btnr               (btnr),
        .btnc               (btnc),
        .led                (led),
        .status_error_uncor (status_error_uncor)
    );

    cc_completion_gen i_cc_gen (
        .clk       (clk),
        .rst       (rst),
        .cpl       (cpl),
        .cpl_valid (cpl_valid),
        .cpl_ready (cpl_ready),
        .cc        (cc),
        .cc_valid  (cc_valid),
        .cc_ready  (cc_ready)
    );

endmodule

// File: hdl/pcie_core_pkg.sv
// Shared widths, field types, descriptor bit positions and request codes for the PCIe BAR0 core.
package pcie_core_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stream and register widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int AXIS_DATA_WIDTH  = 256;
    localparam int AXIS_KEEP_WIDTH  = AXIS_DATA_WIDTH / 32; // one keep bit per dword.
    localparam int CQ_USER_WIDTH    = 8;    // first byte enable sits in bits 3:0.
    localparam int REG_ADDR_WIDTH   = 4;    // 16 dword registers in BAR0.
    localparam int DW_COUNT_WIDTH   = 11;
    localparam int BYTE_COUNT_WIDTH = 13;
    localparam int BAR_ID_WIDTH     = 3;
    localparam int LOWER_ADDR_WIDTH = 7;

    typedef logic [AXIS_DATA_WIDTH-1:0] axis_data_t;
    typedef logic [AXIS_KEEP_WIDTH-1:0] axis_keep_t;
    typedef logic [31:0]                data_word_t;
    typedef logic [3:0]                 byte_en_t;
    typedef logic [REG_ADDR_WIDTH-1:0]  reg_addr_t;
    typedef logic [3:0]                 req_type_t;
    typedef logic [1:0]                 req_kind_t;
    typedef logic [15:0]                requester_id_t;
    typedef logic [7:0]                 tag_t;
    typedef logic [2:0]                 cpl_status_t;
    typedef logic [7:0]                 led_t;

    // request types as carried in the CQ descriptor.
    localparam req_type_t REQ_MEM_READ  = 4'd0;
    localparam req_type_t REQ_MEM_WRITE = 4'd1;

    localparam cpl_status_t CPL_SC = 3'd0; // successful completion.
    localparam cpl_status_t CPL_UR = 3'd1; // unsupported request.

    // the parser decides the kind once, later stages only follow it.
    localparam req_kind_t KIND_READ      = 2'd0;
    localparam req_kind_t KIND_WRITE     = 2'd1;
    localparam req_kind_t KIND_BAD_READ  = 2'd2;
    localparam req_kind_t KIND_BAD_WRITE = 2'd3;

    localparam reg_addr_t REG_LED    = 4'd0;
    localparam reg_addr_t REG_STATUS = 4'd1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // completer descriptor layouts, low bit of each field
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int CQ_ADDR_LSB     = 2;
    localparam int CQ_DW_COUNT_LSB = 64;
    localparam int CQ_REQ_TYPE_LSB = 75;
    localparam int CQ_REQ_ID_LSB   = 80;
    localparam int CQ_TAG_LSB      = 96;
    localparam int CQ_BAR_ID_LSB   = 112;
    localparam int CQ_WR_DATA_LSB  = 128;

    localparam int CC_LOWER_ADDR_LSB = 0;
    localparam int CC_BYTE_COUNT_LSB = 16;
    localparam int CC_DW_COUNT_LSB   = 32;
    localparam int CC_STATUS_LSB     = 43;
    localparam int CC_REQ_ID_LSB     = 48;
    localparam int CC_TAG_LSB        = 64;
    localparam int CC_RD_DATA_LSB    = 96;

    typedef struct packed {
        axis_data_t               data;
        axis_keep_t               keep;
        logic                     last;
        logic [CQ_USER_WIDTH-1:0] user;
    } cq_beat_t;

    typedef struct packed {
        axis_data_t data;
        axis_keep_t keep;
        logic       last;
    } cc_beat_t;

    typedef struct packed {
        req_kind_t                   kind;
        reg_addr_t                   addr;
        byte_en_t                    be;
        data_word_t                  data;
        requester_id_t               requester_id;
        tag_t                        tag;
        logic [LOWER_ADDR_WIDTH-1:0] lower_addr;
    } req_rec_t;

    typedef struct packed {
        cpl_status_t                 status;
        data_word_t                  data;
        requester_id_t               requester_id;
        tag_t                        tag;
        logic [LOWER_ADDR_WIDTH-1:0] lower_addr;
    } cpl_rec_t;

endpackage

// File: tb/tb_checks.svh
// Compare tasks, xorshift generator and BAR0 reference model, included into the core testbench.
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// compare tasks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic compare_field(input string sig, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
        $display("mismatch at %0t ns: %s expected %0h got %0h", $time, sig, exp, got);
        error_count++;
    end
endtask

// decodes one CC beat against the completer completion layout.
task automatic check_cpl(input cc_beat_t beat, input cpl_status_t exp_status,
                         input data_word_t exp_data, input tag_t exp_tag,
                         input logic [6:0] exp_lower);
    logic is_sc;
    is_sc = (exp_status == CPL_SC);
    compare_field("cc status", exp_status, beat.data[45:43]);
    compare_field("cc read data", exp_data, beat.data[127:96]);
    compare_field("cc tag", exp_tag, beat.data[71:64]);
    compare_field("cc requester id", {REQ_ID_HI, exp_tag}, beat.data[63:48]);
    compare_field("cc lower address", exp_lower, beat.data[6:0]);
    compare_field("cc byte count", 4, beat.data[28:16]);
    compare_field("cc dword count", is_sc ? 1 : 0, beat.data[42:32]);
    compare_field("cc keep", is_sc ? 8'h0f : 8'h07, beat.keep); // UR carries no payload dword.
    compare_field("cc last", 1, beat.last);
endtask

task automatic check_led(input led_t exp);
    compare_field("led", exp, led);
endtask

task automatic check_error(input int exp_pulses, input int got_pulses);
    compare_field("status_error_uncor pulses", exp_pulses, got_pulses);
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// random source and register model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
function automatic logic [31:0] next_rand(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

data_word_t model_regs [16]; // expected contents of BAR0.

// register 1 is read-only, so writes to it leave the model alone.
task automatic model_write(input reg_addr_t idx, input byte_en_t be, input data_word_t data);
    if (idx != 4'd1) begin
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                model_regs[idx][8*b +: 8] = data[8*b +: 8];
            end
        end
    end
endtask

function automatic data_word_t model_read(input reg_addr_t idx);
    return model_regs[idx];
endfunction

`endif

// File: tb/tb_fpga_core.sv
// Testbench for the PCIe BAR0 endpoint core; runs a directed request table, then random traffic.
`timescale 1ns/10ps

module tb_fpga_core;

    import pcie_core_pkg::*;

    localparam int          CLK_PERIOD      = 4;
    localparam int          NUM_ENTRIES     = 16;
    localparam int          RAND_COUNT      = 64;
    localparam int          WATCHDOG_CYCLES = 40 * (NUM_ENTRIES + RAND_COUNT) + 20;
    localparam logic [31:0] SEED            = 32'd99632;
    localparam logic [7:0]  REQ_ID_HI       = 8'hc0; // upper byte of every requester id.

    localparam req_type_t   RD = REQ_MEM_READ;
    localparam req_type_t   WR = REQ_MEM_WRITE;
    localparam cpl_status_t SC = CPL_SC;
    localparam cpl_status_t UR = CPL_UR;

    typedef struct {
        string       name;
        req_type_t   req_type;
        int          addr;        // byte address inside the BAR.
        int          bar_id;
        int          dw_count;
        int          be;
        data_word_t  wdata;
        int          tag;
        bit          exp_cpl;
        cpl_status_t exp_status;
        data_word_t  exp_data;
        led_t        exp_led;
        int          exp_errors;
    } entry_t;

    typedef struct packed {
        cpl_status_t status;
        data_word_t  data;
        tag_t        tag;
        logic [6:0]  lower;
    } exp_cpl_t;

    logic        clk;
    logic        rst;
    logic        btnu;
    logic        btnl;
    logic        btnd;
    logic        btnr;
    logic        btnc;
    logic [3:0]  sw;
    led_t        led;
    cq_beat_t    cq;
    logic        cq_valid;
    logic        cq_ready;
    cc_beat_t    cc;
    logic        cc_valid;
    logic        cc_ready;
    logic        status_error_uncor;

    entry_t      tests [NUM_ENTRIES];
    cc_beat_t    got_q [$];
    exp_cpl_t    exp_q [$];
    int          error_count  = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          err_pulses   = 0;
    bit          rand_ready   = 1'b0;
    logic [31:0] stim_state;
    logic [31:0] ready_state;

    `include "tb_checks.svh"

    fpga_core i_dut (
        .clk                (clk),
        .rst                (rst),
        .btnu               (btnu),
        .btnl               (btnl),
        .btnd               (btnd),
        .btnr               (btnr),
        .btnc               (btnc),
        .sw                 (sw),
        .led                (led),
        .cq                 (cq),
        .cq_valid           (cq_valid),
        .cq_ready           (cq_ready),
        .cc                 (cc),
        .cc_valid           (cc_valid),
        .cc_ready           (cc_ready),
        .status_error_uncor (status_error_uncor)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request table; switches 0xa and buttons u d r give status 0x16a
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        tests[0]  = '{"led low byte", WR, 'h00, 0, 1, 'h1, 32'h123456a5, 'h01, 1'b0, SC, 0, 8'ha5, 0};
        tests[1]  = '{"led upper bytes", WR, 'h00, 0, 1, 'he, 32'hffffff3c, 'h02, 1'b0, SC, 0, 8'ha5, 0};
        tests[2]  = '{"read reg0", RD, 'h00, 0, 1, 'hf, 0, 'h03, 1'b1, SC, 32'hffffffa5, 8'ha5, 0};
        tests[3]  = '{"read status", RD, 'h04, 0, 1, 'hf, 0, 'h04, 1'b1, SC, 32'h16a, 8'ha5, 0};
        tests[4]  = '{"write status", WR, 'h04, 0, 1, 'hf, 32'hffffffff, 'h05, 1'b0, SC, 0, 8'ha5, 0};
        tests[5]  = '{"status kept", RD, 'h04, 0, 1, 'hf, 0, 'h06, 1'b1, SC, 32'h16a, 8'ha5, 0};
        tests[6]  = '{"write scratch", WR, 'h14, 0, 1, 'hf, 32'hdeadbeef, 'h07, 1'b0, SC, 0, 8'ha5, 0};
        tests[7]  = '{"read scratch", RD, 'h14, 0, 1, 'hf, 0, 'h08, 1'b1, SC, 32'hdeadbeef, 8'ha5, 0};
        tests[8]  = '{"read bar2", RD, 'h14, 2, 1, 'hf, 0, 'h09, 1'b1, UR, 0, 8'ha5, 1};
        tests[9]  = '{"read dw count 2", RD, 'h14, 0, 2, 'hf, 0, 'h0a, 1'b1, UR, 0, 8'ha5, 1};
        tests[10] = '{"unknown type", 4'h2, 'h14, 0, 1, 'hf, 0, 'h0b, 1'b1, UR, 0, 8'ha5, 1};
        tests[11] = '{"write bar2", WR, 'h00, 2, 1, 'hf, 32'h000000ff, 'h0c, 1'b0, SC, 0, 8'ha5, 1};
        tests[12] = '{"write dw count 2", WR, 'h14, 0, 2, 'hf, 0, 'h0d, 1'b0, SC, 0, 8'ha5, 1};
        tests[13] = '{"scratch kept", RD, 'h14, 0, 1, 'hf, 0, 'h0e, 1'b1, SC, 32'hdeadbeef, 8'ha5, 0};
        tests[14] = '{"lower address", RD, 'hbc, 0, 1, 'hf, 0, 'h0f, 1'b1, SC, 0, 8'ha5, 0};
        tests[15] = '{"led rewrite", WR, 'h00, 0, 1, 'h1, 32'h0000005a, 'h10, 1'b0, SC, 0, 8'h5a, 0};
    end

    function automatic cq_beat_t build_beat(input req_type_t req_type, input int addr,
                                            input int bar_id, input int dw_count, input int be,
                                            input data_word_t wdata, input int tag);
        cq_beat_t beat;
        beat = '0;
        beat.data[63:2]    = 62'(addr >> 2);
        beat.data[74:64]   = 11'(dw_count);
        beat.data[78:75]   = req_type;
        beat.data[95:80]   = {REQ_ID_HI, 8'(tag)};
        beat.data[103:96]  = 8'(tag);
        beat.data[114:112] = 3'(bar_id);
        beat.data[159:128] = wdata;
        beat.keep = (req_type == WR) ? 8'h1f : 8'h0f; // writes carry one payload dword.
        beat.last = 1'b1;
        beat.user = {4'h0, 4'(be)};
        return beat;
    endfunction

    // called 1 ns after an edge and returns 1 ns after the edge that took the beat.
    task automatic send_beat(input cq_beat_t beat);
        bit done;
        done     = 1'b0;
        cq       = beat;
        cq_valid = 1'b1;
        while (!done) begin
            #2;
            done = cq_ready;
            @(posedge clk);
            #1;
        end
        cq_valid = 1'b0;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail", tests_run, name);
        end
    endtask

    task automatic run_entry(input entry_t e);
        int errors_before;
        int pulses_before;
        errors_before = error_count;
        pulses_before = err_pulses;
        send_beat(build_beat(e.req_type, e.addr, e.bar_id, e.dw_count, e.be, e.wdata, e.tag));
        if (e.exp_cpl) begin
            while (got_q.size() == 0) begin
                @(posedge clk);
                #2;
            end
            check_cpl(got_q.pop_front(), e.exp_status, e.exp_data, 8'(e.tag), 7'(e.addr));
        end else begin
            repeat (4) @(posedge clk); // past the write edge and any stray completion.
            #2;
            if (got_q.size() != 0) begin
                $display("a completion came back for write request %s", e.name);
                error_count++;
                got_q.delete();
            end
        end
        check_led(e.exp_led);
        check_error(e.exp_errors, err_pulses - pulses_before);
        if (e.req_type == WR && e.exp_errors == 0) begin
            model_write(reg_addr_t'(e.addr >> 2), byte_en_t'(e.be), e.wdata);
        end
        finish_test(e.name, errors_before);
        @(posedge clk);
        #1;
    endtask

    // back-to-back scratch traffic while the CC side stalls at random.
    task automatic run_random();
        int          errors_before;
        int          pulses_before;
        logic [31:0] r;
        logic [31:0] wdata;
        reg_addr_t   idx;
        exp_cpl_t    exp;
        errors_before = error_count;
        pulses_before = err_pulses;
        #1;
        rand_ready = 1'b1;
        @(posedge clk);
        #1;
        for (int k = 0; k < RAND_COUNT; k++) begin
            stim_state = next_rand(stim_state);
            r          = stim_state;
            stim_state = next_rand(stim_state);
            wdata      = stim_state;
            idx        = reg_addr_t'(2 + r[7:4] % 14); // scratch registers 2 to 15.
            if (r[0]) begin
                exp_q.push_back(exp_cpl_t'{SC, model_read(idx), 8'('h40 + k), 7'(4 * idx)});
                send_beat(build_beat(RD, 4 * idx, 0, 1, 'hf, 0, 'h40 + k));
            end else begin
                model_write(idx, r[11:8], wdata);
                send_beat(build_beat(WR, 4 * idx, 0, 1, int'(r[11:8]), wdata, 'h40 + k));
            end
        end
        while (got_q.size() < exp_q.size()) begin
            @(posedge clk);
            #2;
        end
        rand_ready = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        if (got_q.size() != exp_q.size()) begin
            $display("random phase got %0d completions for %0d reads", got_q.size(), exp_q.size());
            error_count++;
        end
        while (got_q.size() > 0 && exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            check_cpl(got_q.pop_front(), exp.status, exp.data, exp.tag, exp.lower);
        end
        got_q.delete();
        exp_q.delete();
        check_error(0, err_pulses - pulses_before);
        finish_test("random back-pressure", errors_before);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // monitor, cc_ready driver and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        #3; // inputs settle 1 ns after the edge, so this is a quiet point.
        if (!rst) begin
            if (cc_valid && cc_ready) begin
                got_q.push_back(cc);
            end
            if (status_error_uncor) begin
                err_pulses++;
            end
        end
    end

    initial begin
        cc_ready    = 1'b1;
        ready_state = next_rand(SEED);
        forever begin
            @(posedge clk);
            #1;
            if (rand_ready) begin
                ready_state = next_rand(ready_state);
                cc_ready    = ready_state[0];
            end else begin
                cc_ready = 1'b1;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the DUT stopped responding", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int errors_before;
        rst        = 1'b1;
        cq         = '0;
        cq_valid   = 1'b0;
        sw         = 4'ha;
        btnu       = 1'b1;
        btnl       = 1'b0;
        btnd       = 1'b1;
        btnr       = 1'b1;
        btnc       = 1'b0;
        stim_state = SEED;
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #2;
        errors_before = error_count;
        check_led(8'h00);
        compare_field("cc_valid", 0, cc_valid);
        compare_field("cq_ready", 1, cq_ready);
        finish_test("reset state", errors_before);
        @(posedge clk);
        #1;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(tests[i]);
        end
        run_random();
        $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+tb
hdl/pcie_core_pkg.sv
hdl/cq_request_parser.sv
hdl/bar_regfile.sv
hdl/cc_completion_gen.sv
hdl/fpga_core.sv
tb/tb_fpga_core.sv
